// ==== sources.f ====
rtl/tcdm_mem_pkg.sv
rtl/tcdm_perf_pkg.sv
rtl/tcdm_addr_decoder.sv
rtl/tcdm_bank_arbiter.sv
rtl/tcdm_sram_bank.sv
rtl/tcdm_resp_router.sv
rtl/tcdm_traffic_counters.sv
rtl/tcdm_mem_top.sv
verif/tb_tcdm_mem.sv

// ==== Makefile ====
# Verilator build and run of the TCDM memory testbench

TOP := tb_tcdm_mem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/10ps -f sources.f \
		--top-module $(TOP) -o $(TOP)

# exit status comes from the search for the pass line
run: compile
	./obj_dir/$(TOP) | awk '{ print } /^>>> PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// ==== verif/tb_tcdm_mem.sv ====
////////////////////////////////////////////////////////////////////////////
// TCDM memory testbench
// random traffic phases checked against a shadow memory and arbiter model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_tcdm_mem;

  import tcdm_mem_pkg::*;
  import tcdm_perf_pkg::*;

  localparam int NM        = 8;
  localparam int NB        = 8;
  localparam int RowBits   = 6;
  localparam int BankW     = $clog2(NB);
  localparam int NW        = NB * (2 ** RowBits);
  localparam int PerMaster = NW / NM;
  localparam int DrainLimit = 64;
  localparam int PhaseLimit = 4000;
  localparam int unsigned Seed = 32'h649e0f12;

  logic clk_i;
  logic rst_ni;
  logic perf_clr_i;
  logic  [NM-1:0] req_i;
  addr_t [NM-1:0] addr_i;
  logic  [NM-1:0] we_i;
  data_t [NM-1:0] wdata_i;
  strb_t [NM-1:0] be_i;
  logic  [NM-1:0] gnt_o;
  logic  [NM-1:0] vld_o;
  data_t [NM-1:0] rdata_o;
  cnt_t  [NM-1:0] req_cnt_o;
  cnt_t  [NM-1:0] gnt_cnt_o;
  cnt_t  [NM-1:0] wait_cnt_o;
  cnt_t  [NB-1:0] bank_cnt_o;

  // pending request of each master held until granted
  logic [NM-1:0] pend;
  logic [NM-1:0] drv_req;
  addr_t p_addr [NM];
  logic  p_we [NM];
  data_t p_wdata [NM];
  strb_t p_be [NM];

  // reference model state
  data_t shadow [NW];
  int    ptr [NB];
  logic [NM-1:0] exp_vld;
  logic  exp_rd [NM];
  data_t exp_rdata [NM];
  cnt_t  exp_req_cnt [NM];
  cnt_t  exp_gnt_cnt [NM];
  cnt_t  exp_wait_cnt [NM];
  cnt_t  exp_bank_cnt [NB];
  logic  clr_drv;

  int errors;
  int checks;
  int tests_run;

  tcdm_mem_top #(
    .NumMaster ( NM      ),
    .NumBanks  ( NB      ),
    .RowBits   ( RowBits )
  ) u_dut (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .perf_clr_i ( perf_clr_i ),
    .req_i      ( req_i      ),
    .addr_i     ( addr_i     ),
    .we_i       ( we_i       ),
    .wdata_i    ( wdata_i    ),
    .be_i       ( be_i       ),
    .gnt_o      ( gnt_o      ),
    .vld_o      ( vld_o      ),
    .rdata_o    ( rdata_o    ),
    .req_cnt_o  ( req_cnt_o  ),
    .gnt_cnt_o  ( gnt_cnt_o  ),
    .wait_cnt_o ( wait_cnt_o ),
    .bank_cnt_o ( bank_cnt_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // model helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic int bank_of(addr_t a);
    return int'(a[ByteOffBits +: BankW]);
  endfunction

  // bank bits and row bits together give the shadow word
  function automatic int word_of(addr_t a);
    return int'(a[ByteOffBits +: BankW + RowBits]);
  endfunction

  function automatic data_t merge_bytes(data_t old_w, data_t new_w, strb_t be);
    data_t res;
    res = old_w;
    for (int j = 0; j < 4; j++) begin
      if (be[j]) begin
        res[j*8 +: 8] = new_w[j*8 +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_val(string name, logic [31:0] exp_v, logic [31:0] act_v);
    checks++;
    if (act_v !== exp_v) begin
      errors++;
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
    end
  endtask

  task automatic issue_req(int m, addr_t a, logic we, data_t d, strb_t be);
    pend[m]    = 1'b1;
    p_addr[m]  = a;
    p_we[m]    = we;
    p_wdata[m] = d;
    p_be[m]    = be;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // one clock cycle of driving, checking and model update
  ////////////////////////////////////////////////////////////////////////////

  task automatic step_cycle();
    logic [NM-1:0] gnt_exp;
    logic found;
    int m;
    int w;
    @(posedge clk_i);
    perf_clr_i <= clr_drv;
    drv_req = pend;
    for (int i = 0; i < NM; i++) begin
      req_i[i]   <= pend[i];
      addr_i[i]  <= p_addr[i];
      we_i[i]    <= p_we[i];
      wdata_i[i] <= p_wdata[i];
      be_i[i]    <= p_be[i];
    end
    @(negedge clk_i);
    // responses to last cycle's grants
    check_val("vld_o", 32'(exp_vld), 32'(vld_o));
    for (int i = 0; i < NM; i++) begin
      if (exp_vld[i] && exp_rd[i]) begin
        check_val($sformatf("rdata_o[%0d]", i), exp_rdata[i], rdata_o[i]);
      end
    end
    // round robin per bank scanning up from the pointer
    gnt_exp = '0;
    for (int b = 0; b < NB; b++) begin
      found = 1'b0;
      for (int k = 0; k < NM; k++) begin
        m = (ptr[b] + k) % NM;
        if (!found && pend[m] && bank_of(p_addr[m]) == b) begin
          found      = 1'b1;
          gnt_exp[m] = 1'b1;
          ptr[b]     = (m + 1) % NM;
        end
      end
      if (found && !clr_drv) begin
        exp_bank_cnt[b] = exp_bank_cnt[b] + 1;
      end
    end
    check_val("gnt_o", 32'(gnt_exp), 32'(gnt_o));
    for (int i = 0; i < NM; i++) begin
      if (!clr_drv) begin
        if (pend[i]) exp_req_cnt[i] = exp_req_cnt[i] + 1;
        if (gnt_exp[i]) exp_gnt_cnt[i] = exp_gnt_cnt[i] + 1;
        if (pend[i] && !gnt_exp[i]) exp_wait_cnt[i] = exp_wait_cnt[i] + 1;
      end else begin
        exp_req_cnt[i]  = '0;
        exp_gnt_cnt[i]  = '0;
        exp_wait_cnt[i] = '0;
      end
      if (gnt_exp[i]) begin
        w = word_of(p_addr[i]);
        exp_rd[i]    = !p_we[i];
        exp_rdata[i] = shadow[w];
        if (p_we[i]) shadow[w] = merge_bytes(shadow[w], p_wdata[i], p_be[i]);
      end
    end
    if (clr_drv) begin
      for (int b = 0; b < NB; b++) exp_bank_cnt[b] = '0;
    end
    exp_vld = gnt_exp;
    pend    = pend & ~gnt_exp;
  endtask

  // wait for outstanding grants and add one idle cycle for the responses
  task automatic drain_pending(string what);
    int n;
    n = 0;
    while (pend != '0 && n < DrainLimit) begin
      step_cycle();
      n++;
    end
    if (pend != '0) begin
      errors++;
      $display("timeout: %s requests never got a grant", what);
      pend = '0;
    end
    step_cycle();
  endtask

  task automatic report_test(string name, int err0, int chk0);
    tests_run++;
    $display("test %-12s done: %0d checks, %0d errors", name, checks - chk0,
             errors - err0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // traffic phases
  ////////////////////////////////////////////////////////////////////////////

  // each master owns a contiguous range so all start on the same bank
  task automatic fill_memory();
    int next [NM];
    int n;
    logic busy;
    for (int m = 0; m < NM; m++) next[m] = 0;
    n    = 0;
    busy = 1'b1;
    while (busy && n < PhaseLimit) begin
      busy = 1'b0;
      for (int m = 0; m < NM; m++) begin
        if (!pend[m] && next[m] < PerMaster) begin
          issue_req(m, addr_t'((m * PerMaster + next[m]) << ByteOffBits), 1'b1,
                    data_t'($urandom()), '1);
          next[m]++;
        end
        if (next[m] < PerMaster) busy = 1'b1;
      end
      step_cycle();
      n++;
    end
    if (busy) begin
      errors++;
      $display("timeout: memory fill did not finish");
    end
    drain_pending("fill");
  endtask

  task automatic uniform_traffic();
    for (int c = 0; c < 400; c++) begin
      for (int m = 0; m < NM; m++) begin
        if (!pend[m] && 1'($urandom())) begin
          issue_req(m, addr_t'($urandom()), 1'($urandom()), data_t'($urandom()),
                    strb_t'($urandom()));
        end
      end
      step_cycle();
    end
    drain_pending("uniform");
  endtask

  task automatic all_to_one();
    addr_t a;
    a = addr_t'($urandom());
    for (int c = 0; c < 64; c++) begin
      for (int m = 0; m < NM; m++) begin
        if (!pend[m]) issue_req(m, a, 1'($urandom()), data_t'($urandom()), '1);
      end
      step_cycle();
      check_val("grant count", 32'd1, 32'($countones(gnt_o)));
    end
    drain_pending("all-to-one");
  endtask

  // distinct banks per master so nobody ever waits
  task automatic permutation_traffic();
    int perm [NB];
    int j;
    int t;
    int row;
    for (int c = 0; c < 100; c++) begin
      for (int b = 0; b < NB; b++) perm[b] = b;
      for (int i = NB - 1; i > 0; i--) begin
        j       = int'($urandom_range(i, 0));
        t       = perm[i];
        perm[i] = perm[j];
        perm[j] = t;
      end
      for (int m = 0; m < NM; m++) begin
        row = int'($urandom_range(2 ** RowBits - 1, 0));
        issue_req(m, addr_t'((row * NB + perm[m]) << ByteOffBits), 1'($urandom()),
                  data_t'($urandom()), strb_t'($urandom()));
      end
      step_cycle();
      check_val("gnt_o vs req_i", 32'(drv_req), 32'(gnt_o));
    end
    drain_pending("permutation");
  endtask

  task automatic counter_burst();
    int base [NM];
    int len [NM];
    int done [NM];
    int n;
    logic busy;
    clr_drv = 1'b1;
    step_cycle();
    clr_drv = 1'b0;
    for (int m = 0; m < NM; m++) begin
      base[m] = int'($urandom_range(NW - 1, 0));
      len[m]  = int'($urandom_range(16, 4));
      done[m] = 0;
    end
    n    = 0;
    busy = 1'b1;
    while (busy && n < PhaseLimit) begin
      busy = 1'b0;
      for (int m = 0; m < NM; m++) begin
        if (!pend[m] && done[m] < len[m]) begin
          issue_req(m, addr_t'(((base[m] + done[m]) % NW) << ByteOffBits),
                    1'($urandom()), data_t'($urandom()), '1);
          done[m]++;
        end
        if (done[m] < len[m]) busy = 1'b1;
      end
      step_cycle();
      n++;
    end
    if (busy) begin
      errors++;
      $display("timeout: linear bursts did not finish");
    end
    drain_pending("burst");
    for (int m = 0; m < NM; m++) begin
      check_val($sformatf("req_cnt_o[%0d]", m), exp_req_cnt[m], req_cnt_o[m]);
      check_val($sformatf("gnt_cnt_o[%0d]", m), exp_gnt_cnt[m], gnt_cnt_o[m]);
      check_val($sformatf("wait_cnt_o[%0d]", m), exp_wait_cnt[m], wait_cnt_o[m]);
    end
    for (int b = 0; b < NB; b++) begin
      check_val($sformatf("bank_cnt_o[%0d]", b), exp_bank_cnt[b], bank_cnt_o[b]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    int e0;
    int c0;
    void'($urandom(Seed));
    errors     = 0;
    checks     = 0;
    tests_run  = 0;
    rst_ni     = 1'b0;
    perf_clr_i = 1'b0;
    req_i      = '0;
    addr_i     = '0;
    we_i       = '0;
    wdata_i    = '0;
    be_i       = '0;
    pend       = '0;
    drv_req    = '0;
    exp_vld    = '0;
    clr_drv    = 1'b0;
    for (int m = 0; m < NM; m++) begin
      p_addr[m]       = '0;
      p_we[m]         = 1'b0;
      p_wdata[m]      = '0;
      p_be[m]         = '0;
      exp_rd[m]       = 1'b0;
      exp_rdata[m]    = '0;
      exp_req_cnt[m]  = '0;
      exp_gnt_cnt[m]  = '0;
      exp_wait_cnt[m] = '0;
    end
    for (int b = 0; b < NB; b++) begin
      ptr[b]          = 0;
      exp_bank_cnt[b] = '0;
    end
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    e0 = errors;
    c0 = checks;
    fill_memory();
    report_test("fill", e0, c0);
    e0 = errors;
    c0 = checks;
    uniform_traffic();
    report_test("uniform", e0, c0);
    e0 = errors;
    c0 = checks;
    all_to_one();
    report_test("all-to-one", e0, c0);
    e0 = errors;
    c0 = checks;
    permutation_traffic();
    report_test("permutation", e0, c0);
    e0 = errors;
    c0 = checks;
    counter_burst();
    report_test("counters", e0, c0);

    $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== rtl/tcdm_mem_top.sv ====
////////////////////////////////////////////////////////////////////////////
// TCDM memory subsystem
// word-interleaved multi-bank memory with per-bank arbitration and counters
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tcdm_mem_top #(
  parameter int unsigned NumMaster = 8,
  parameter int unsigned NumBanks  = 8,
  parameter int unsigned RowBits   = 6
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 perf_clr_i,
  // master ports
  input  logic                 [NumMaster-1:0] req_i,
  input  tcdm_mem_pkg::addr_t  [NumMaster-1:0] addr_i,
  input  logic                 [NumMaster-1:0] we_i,
  input  tcdm_mem_pkg::data_t  [NumMaster-1:0] wdata_i,
  input  tcdm_mem_pkg::strb_t  [NumMaster-1:0] be_i,
  output logic                 [NumMaster-1:0] gnt_o,
  output logic                 [NumMaster-1:0] vld_o,
  output tcdm_mem_pkg::data_t  [NumMaster-1:0] rdata_o,
  // traffic statistics
  output tcdm_perf_pkg::cnt_t  [NumMaster-1:0] req_cnt_o,
  output tcdm_perf_pkg::cnt_t  [NumMaster-1:0] gnt_cnt_o,
  output tcdm_perf_pkg::cnt_t  [NumMaster-1:0] wait_cnt_o,
  output tcdm_perf_pkg::cnt_t  [NumBanks-1:0]  bank_cnt_o
);

  import tcdm_mem_pkg::*;

  logic [NumBanks-1:0][NumMaster-1:0] bank_req;
  logic [NumBanks-1:0][NumMaster-1:0] bank_gnt;
  logic [NumMaster-1:0][RowBits-1:0]  mst_row;

  // bank side of the arbiters
  logic  [NumBanks-1:0]               bank_cs;
  logic  [NumBanks-1:0]               bank_we;
  logic  [NumBanks-1:0][RowBits-1:0]  bank_row;
  data_t [NumBanks-1:0]               bank_wdata;
  strb_t [NumBanks-1:0]               bank_be;
  data_t [NumBanks-1:0]               bank_rdata;

  ////////////////////////////////////////////////////////////////////////////
  // request path
  ////////////////////////////////////////////////////////////////////////////

  tcdm_addr_decoder #(
    .NumMaster ( NumMaster ),
    .NumBanks  ( NumBanks  ),
    .RowBits   ( RowBits   )
  ) u_decoder (
    .addr_i     ( addr_i   ),
    .req_i      ( req_i    ),
    .bank_req_o ( bank_req ),
    .row_o      ( mst_row  )
  );

  for (genvar b = 0; b < NumBanks; b++) begin : g_bank
    tcdm_bank_arbiter #(
      .NumMaster ( NumMaster ),
      .RowBits   ( RowBits   )
    ) u_arbiter (
      .clk_i      ( clk_i         ),
      .rst_ni     ( rst_ni        ),
      .bank_req_i ( bank_req[b]   ),
      .row_i      ( mst_row       ),
      .we_i       ( we_i          ),
      .wdata_i    ( wdata_i       ),
      .be_i       ( be_i          ),
      .gnt_o      ( bank_gnt[b]   ),
      .cs_o       ( bank_cs[b]    ),
      .we_o       ( bank_we[b]    ),
      .row_o      ( bank_row[b]   ),
      .wdata_o    ( bank_wdata[b] ),
      .be_o       ( bank_be[b]    )
    );

    tcdm_sram_bank #(
      .RowBits ( RowBits )
    ) u_sram (
      .clk_i   ( clk_i         ),
      .cs_i    ( bank_cs[b]    ),
      .we_i    ( bank_we[b]    ),
      .row_i   ( bank_row[b]   ),
      .wdata_i ( bank_wdata[b] ),
      .be_i    ( bank_be[b]    ),
      .rdata_o ( bank_rdata[b] )
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // response path and statistics
  ////////////////////////////////////////////////////////////////////////////

  tcdm_resp_router #(
    .NumMaster ( NumMaster ),
    .NumBanks  ( NumBanks  )
  ) u_router (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .bank_gnt_i   ( bank_gnt   ),
    .bank_rdata_i ( bank_rdata ),
    .gnt_o        ( gnt_o      ),
    .vld_o        ( vld_o      ),
    .rdata_o      ( rdata_o    )
  );

  tcdm_traffic_counters #(
    .NumMaster ( NumMaster ),
    .NumBanks  ( NumBanks  )
  ) u_counters (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .perf_clr_i ( perf_clr_i ),
    .req_i      ( req_i      ),
    .gnt_i      ( gnt_o      ),
    .bank_cs_i  ( bank_cs    ),
    .req_cnt_o  ( req_cnt_o  ),
    .gnt_cnt_o  ( gnt_cnt_o  ),
    .wait_cnt_o ( wait_cnt_o ),
    .bank_cnt_o ( bank_cnt_o )
  );

endmodule

// ==== rtl/tcdm_traffic_counters.sv ====
////////////////////////////////////////////////////////////////////////////
// TCDM traffic counters
// per-master request, grant and wait counts, per-bank access counts
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tcdm_traffic_counters #(
  parameter int unsigned NumMaster = 8,
  parameter int unsigned NumBanks  = 8
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  perf_clr_i,
  input  logic                 [NumMaster-1:0]  req_i,
  input  logic                 [NumMaster-1:0]  gnt_i,
  input  logic                 [NumBanks-1:0]   bank_cs_i,
  output tcdm_perf_pkg::cnt_t  [NumMaster-1:0]  req_cnt_o,
  output tcdm_perf_pkg::cnt_t  [NumMaster-1:0]  gnt_cnt_o,
  output tcdm_perf_pkg::cnt_t  [NumMaster-1:0]  wait_cnt_o,
  output tcdm_perf_pkg::cnt_t  [NumBanks-1:0]   bank_cnt_o
);

  import tcdm_perf_pkg::*;

  localparam cnt_t CntOne = cnt_t'(1);

  logic [NumMaster-1:0] wait_evt;

  // requested but not served this cycle
  assign wait_evt = req_i & ~gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_cnt
    if (!rst_ni) begin
      req_cnt_o  <= '0;
      gnt_cnt_o  <= '0;
      wait_cnt_o <= '0;
      bank_cnt_o <= '0;
    end else if (perf_clr_i) begin
      // events of the clear cycle are dropped
      req_cnt_o  <= '0;
      gnt_cnt_o  <= '0;
      wait_cnt_o <= '0;
      bank_cnt_o <= '0;
    end else begin
      for (int unsigned m = 0; m < NumMaster; m++) begin
        if (req_i[m]) begin
          req_cnt_o[m] <= req_cnt_o[m] + CntOne;
        end
        if (gnt_i[m]) begin
          gnt_cnt_o[m] <= gnt_cnt_o[m] + CntOne;
        end
        if (wait_evt[m]) begin
          wait_cnt_o[m] <= wait_cnt_o[m] + CntOne;
        end
      end
      // one access per selected bank
      for (int unsigned b = 0; b < NumBanks; b++) begin
        if (bank_cs_i[b]) begin
          bank_cnt_o[b] <= bank_cnt_o[b] + CntOne;
        end
      end
    end
  end

endmodule

// ==== rtl/tcdm_resp_router.sv ====
////////////////////////////////////////////////////////////////////////////
// TCDM response router
// merges bank grants per master and returns read data one cycle later
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tcdm_resp_router #(
  parameter int unsigned NumMaster = 8,
  parameter int unsigned NumBanks  = 8
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                [NumBanks-1:0][NumMaster-1:0] bank_gnt_i,
  input  tcdm_mem_pkg::data_t [NumBanks-1:0]                bank_rdata_i,
  output logic                [NumMaster-1:0]               gnt_o,
  output logic                [NumMaster-1:0]               vld_o,
  output tcdm_mem_pkg::data_t [NumMaster-1:0]               rdata_o
);

  localparam int unsigned BankIdxW = $clog2(NumBanks);

  logic [NumMaster-1:0][BankIdxW-1:0] bank_sel_d;
  logic [NumMaster-1:0][BankIdxW-1:0] bank_sel_q;

  // a master wins at most one bank per cycle, so OR and encode
  always_comb begin : p_merge
    gnt_o      = '0;
    bank_sel_d = '0;
    for (int unsigned m = 0; m < NumMaster; m++) begin
      for (int unsigned b = 0; b < NumBanks; b++) begin
        if (bank_gnt_i[b][m]) begin
          gnt_o[m]      = 1'b1;
          bank_sel_d[m] = BankIdxW'(b);
        end
      end
    end
  end

  // response valid follows every grant by one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_vld
    if (!rst_ni) begin
      vld_o <= '0;
    end else begin
      vld_o <= gnt_o;
    end
  end

  // served bank, kept until the next grant of that master
  always_ff @(posedge clk_i) begin : p_bank_sel
    for (int unsigned m = 0; m < NumMaster; m++) begin
      if (gnt_o[m]) begin
        bank_sel_q[m] <= bank_sel_d[m];
      end
    end
  end

  always_comb begin : p_rdata
    for (int unsigned m = 0; m < NumMaster; m++) begin
      rdata_o[m] = bank_rdata_i[bank_sel_q[m]];
    end
  end

endmodule

// ==== rtl/tcdm_sram_bank.sv ====
////////////////////////////////////////////////////////////////////////////
// TCDM SRAM bank
// single-port word array with byte-enabled writes and registered reads
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tcdm_sram_bank #(
  parameter int unsigned RowBits = 6
) (
  input  logic                clk_i,
  input  logic                cs_i,
  input  logic                we_i,
  input  logic [RowBits-1:0]  row_i,
  input  tcdm_mem_pkg::data_t wdata_i,
  input  tcdm_mem_pkg::strb_t be_i,
  output tcdm_mem_pkg::data_t rdata_o
);

  import tcdm_mem_pkg::*;

  localparam int unsigned NumWords = 2 ** RowBits;

  data_t mem_q [NumWords];

  // write port, only enabled byte lanes change
  always_ff @(posedge clk_i) begin : p_write
    if (cs_i && we_i) begin
      for (int unsigned j = 0; j < StrbWidth; j++) begin
        if (be_i[j]) begin
          mem_q[row_i][j*8 +: 8] <= wdata_i[j*8 +: 8];
        end
      end
    end
  end

  // read data holds until the next selected read
  always_ff @(posedge clk_i) begin : p_read
    if (cs_i && !we_i) begin
      rdata_o <= mem_q[row_i];
    end
  end

endmodule

// ==== rtl/tcdm_bank_arbiter.sv ====
////////////////////////////////////////////////////////////////////////////
// TCDM bank arbiter
// round-robin pick among the requesters of one bank, winner drives the bank
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tcdm_bank_arbiter #(
  parameter int unsigned NumMaster = 8,
  parameter int unsigned RowBits   = 6
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                [NumMaster-1:0]               bank_req_i,
  input  logic                [NumMaster-1:0][RowBits-1:0]  row_i,
  input  logic                [NumMaster-1:0]               we_i,
  input  tcdm_mem_pkg::data_t [NumMaster-1:0]               wdata_i,
  input  tcdm_mem_pkg::strb_t [NumMaster-1:0]               be_i,
  output logic                [NumMaster-1:0]               gnt_o,
  output logic                                    cs_o,
  output logic                                    we_o,
  output logic                [RowBits-1:0]       row_o,
  output tcdm_mem_pkg::data_t                     wdata_o,
  output tcdm_mem_pkg::strb_t                     be_o
);

  localparam int unsigned MstIdxW = $clog2(NumMaster);
  // one extra bit so pointer plus offset never overflows
  localparam int unsigned PtrSumW = MstIdxW + 1;

  logic [MstIdxW-1:0] ptr_q;
  logic [MstIdxW-1:0] ptr_d;
  logic [MstIdxW-1:0] sel_idx;
  logic               found;

  ////////////////////////////////////////////////////////////////////////////
  // winner selection
  ////////////////////////////////////////////////////////////////////////////

  // scan from the pointer upwards and wrap, first requester wins
  always_comb begin : p_pick
    logic [PtrSumW-1:0] cand;
    found   = 1'b0;
    sel_idx = ptr_q;
    gnt_o   = '0;
    for (int unsigned i = 0; i < NumMaster; i++) begin
      cand = {1'b0, ptr_q} + PtrSumW'(i);
      if (cand >= PtrSumW'(NumMaster)) begin
        cand = cand - PtrSumW'(NumMaster);
      end
      if (!found && bank_req_i[cand[MstIdxW-1:0]]) begin
        found   = 1'b1;
        sel_idx = cand[MstIdxW-1:0];
      end
    end
    if (found) begin
      gnt_o[sel_idx] = 1'b1;
    end
  end

  // next pointer is one past the winner
  always_comb begin : p_ptr_next
    if (sel_idx == MstIdxW'(NumMaster - 1)) begin
      ptr_d = '0;
    end else begin
      ptr_d = sel_idx + MstIdxW'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ptr
    if (!rst_ni) begin
      ptr_q <= '0;
    end else if (found) begin
      ptr_q <= ptr_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // request mux onto the bank
  ////////////////////////////////////////////////////////////////////////////

  assign cs_o    = found;
  assign we_o    = we_i[sel_idx];
  assign row_o   = row_i[sel_idx];
  assign wdata_o = wdata_i[sel_idx];
  assign be_o    = be_i[sel_idx];

endmodule

// ==== rtl/tcdm_addr_decoder.sv ====
////////////////////////////////////////////////////////////////////////////
// TCDM address decoder
// splits master addresses into bank and row, builds the bank request matrix
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tcdm_addr_decoder #(
  parameter int unsigned NumMaster = 8,
  parameter int unsigned NumBanks  = 8,
  parameter int unsigned RowBits   = 6
) (
  input  tcdm_mem_pkg::addr_t [NumMaster-1:0]                addr_i,
  input  logic                [NumMaster-1:0]                req_i,
  output logic                [NumBanks-1:0][NumMaster-1:0]  bank_req_o,
  output logic                [NumMaster-1:0][RowBits-1:0]   row_o
);

  import tcdm_mem_pkg::*;

  localparam int unsigned BankIdxW = $clog2(NumBanks);

  logic [NumMaster-1:0][BankIdxW-1:0] bank_idx;

  // word interleaving, bank index sits right above the byte offset
  always_comb begin : p_split
    for (int unsigned m = 0; m < NumMaster; m++) begin
      bank_idx[m] = addr_i[m][ByteOffBits +: BankIdxW];
      row_o[m]    = addr_i[m][ByteOffBits + BankIdxW +: RowBits];
    end
  end

  // conflict matrix, one row per bank
  always_comb begin : p_matrix
    for (int unsigned b = 0; b < NumBanks; b++) begin
      for (int unsigned m = 0; m < NumMaster; m++) begin
        bank_req_o[b][m] = req_i[m] && (bank_idx[m] == BankIdxW'(b));
      end
    end
  end

endmodule

// ==== rtl/tcdm_perf_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// TCDM traffic statistics package
////////////////////////////////////////////////////////////////////////////

package tcdm_perf_pkg;

  // counter width, counters wrap at the top
  localparam int unsigned CntWidth = 32;

  // one traffic counter
  typedef logic [CntWidth-1:0] cnt_t;

endpackage

// ==== rtl/tcdm_mem_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// TCDM memory package
// word, byte-enable and address types of the shared memory datapath
////////////////////////////////////////////////////////////////////////////

package tcdm_mem_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // word geometry
  ////////////////////////////////////////////////////////////////////////////

  // bits per memory word
  localparam int unsigned DataWidth   = 32;
  // one enable per byte lane
  localparam int unsigned StrbWidth   = DataWidth / 8;
  // byte offset inside a word, ignored by the banks
  localparam int unsigned ByteOffBits = $clog2(StrbWidth);

  // byte address as issued by a master
  localparam int unsigned AddrWidth   = 32;

  ////////////////////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;
  typedef logic [AddrWidth-1:0] addr_t;

endpackage
